// File: clint_settings.svh
/* Address map, bus widths and timer prescaler of the CLINT.
   Included by the package and by every block that needs one of these values. */

`ifndef CLINT_SETTINGS_SVH
`define CLINT_SETTINGS_SVH

// ----------------------------------------------------------------------------
// address map
// ----------------------------------------------------------------------------

`define CLINT_BASE_ADDR     32'h0200_0000  // block base on the mmio port
`define CLINT_MSIP_OFS      32'h0000_0000  // software interrupt bit
`define CLINT_MTIMECMP_OFS  32'h0000_4000  // timer compare, 64 bits
`define CLINT_MTIME_OFS     32'h0000_bff8  // free-running time, 64 bits

// ----------------------------------------------------------------------------
// bus and timer widths
// ----------------------------------------------------------------------------

`define CLINT_ADDR_W      32  // request address
`define CLINT_TAG_W       4   // request tag, echoed on the response
`define CLINT_XLEN        64  // one data word, no byte-lane shift

// mtime steps when the prescaler wraps, i.e. once every 2**6 = 64 cycles
`define CLINT_TICK_DIV_W  6

`endif

// File: clint_pkg.sv
/* Shared types of the CLINT bus and registers, plus the byte-lane merge
   used for every byte-enabled register write. */

`include "clint_settings.svh"

package clint_pkg;

  // --------------------------------------------------------------------------
  // bus types
  // --------------------------------------------------------------------------

  typedef enum logic [1:0] {
    M_XRD = 2'b00,  // load
    M_XWR = 2'b01   // store
  } mem_cmd_t;

  typedef logic [`CLINT_XLEN-1:0]   xlen_t;
  typedef logic [`CLINT_TAG_W-1:0]  tag_t;
  typedef logic [`CLINT_XLEN/8-1:0] be_t;

  // keeps the old byte where the lane is not enabled
  function automatic xlen_t merge_bytes(input xlen_t old_val, input xlen_t new_val,
                                        input be_t byte_en);
    xlen_t merged;
    for (int b = 0; b < `CLINT_XLEN/8; b++) begin
      merged[b*8 +: 8] = byte_en[b] ? new_val[b*8 +: 8] : old_val[b*8 +: 8];
    end
    return merged;
  endfunction

endpackage

// File: clint_timebase.sv
/* Prescaler and mtime counter. mtime steps once per prescaler wrap, and a
   software store loads it per byte lane, taking priority over the step. */

`include "clint_settings.svh"

module clint_timebase (
  input  logic             i_clk,
  input  logic             i_reset_n,

  input  logic             i_mtime_we,
  input  clint_pkg::xlen_t i_wr_data,
  input  clint_pkg::be_t   i_wr_byte_en,

  output clint_pkg::xlen_t o_mtime
);

  import clint_pkg::*;

  logic [`CLINT_TICK_DIV_W-1:0] r_prescale;
  logic                         w_tick;
  xlen_t                        r_mtime;

  // --------------------------------------------------------------------------
  // prescaler
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_prescale <= '0;
    end else begin
      r_prescale <= r_prescale + 1'b1;  // free-running, wraps
    end
  end

  assign w_tick = &r_prescale;  // last cycle of each period

  // --------------------------------------------------------------------------
  // mtime
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mtime <= '0;
    end else if (i_mtime_we) begin
      r_mtime <= merge_bytes(r_mtime, i_wr_data, i_wr_byte_en);  // store wins over tick
    end else if (w_tick) begin
      r_mtime <= r_mtime + 1'b1;
    end
  end

  assign o_mtime = r_mtime;

  // without a store, time only holds or steps by one
  a_mtime_step: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !i_mtime_we |=> (r_mtime == $past(r_mtime)) || (r_mtime == $past(r_mtime) + 1'b1))
    else $error("mtime jumped without a store");

endmodule

// File: clint_regs.sv
/* msip and mtimecmp storage with the interrupt lines. The timer level is
   mtime >= mtimecmp, and each mtimecmp store raises the clear pulse. */

`include "clint_settings.svh"

module clint_regs (
  input  logic             i_clk,
  input  logic             i_reset_n,

  input  logic             i_msip_we,
  input  logic             i_mtimecmp_we,
  input  clint_pkg::xlen_t i_wr_data,
  input  clint_pkg::be_t   i_wr_byte_en,
  input  clint_pkg::xlen_t i_mtime,

  output logic             o_msip,
  output clint_pkg::xlen_t o_mtimecmp,
  output logic             o_ipi,
  output logic             o_timer_irq,
  output logic             o_timer_irq_clear
);

  import clint_pkg::*;

  logic  r_msip;
  xlen_t r_mtimecmp;

  // --------------------------------------------------------------------------
  // msip
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_msip <= 1'b0;
    end else if (i_msip_we && i_wr_byte_en[0]) begin
      r_msip <= i_wr_data[0];  // upper bits are reserved
    end
  end

  // --------------------------------------------------------------------------
  // mtimecmp
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mtimecmp <= '0;
    end else if (i_mtimecmp_we) begin
      r_mtimecmp <= merge_bytes(r_mtimecmp, i_wr_data, i_wr_byte_en);
    end
  end

  // --------------------------------------------------------------------------
  // interrupt lines
  // --------------------------------------------------------------------------

  assign o_msip     = r_msip;      // read-back path
  assign o_mtimecmp = r_mtimecmp;
  assign o_ipi      = r_msip;

  // level, so high out of reset with both values at zero
  assign o_timer_irq = (i_mtime >= r_mtimecmp);

  // lets the hart drop a pending timer interrupt in the store cycle
  assign o_timer_irq_clear = i_mtimecmp_we;

  // the compare value only moves right after a clear pulse
  a_cmp_needs_clear: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_mtimecmp != $past(r_mtimecmp)) |-> $past(o_timer_irq_clear))
    else $error("mtimecmp changed without a clear pulse");

endmodule

// File: clint_bus_slave.sv
/* Request/response slave of the CLINT. Decodes the full address into write
   strobes and a registered read response that is held while stalled. */

`include "clint_settings.svh"

module clint_bus_slave (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  // request channel
  input  logic                     i_req_valid,
  input  clint_pkg::mem_cmd_t      i_req_cmd,
  input  logic [`CLINT_ADDR_W-1:0] i_req_addr,
  input  clint_pkg::tag_t          i_req_tag,
  input  clint_pkg::xlen_t         i_req_data,
  input  clint_pkg::be_t           i_req_byte_en,
  output logic                     o_req_ready,

  // response channel
  output logic                     o_resp_valid,
  output clint_pkg::tag_t          o_resp_tag,
  output clint_pkg::xlen_t         o_resp_data,
  input  logic                     i_resp_ready,

  // register side
  input  logic                     i_msip,
  input  clint_pkg::xlen_t         i_mtimecmp,
  input  clint_pkg::xlen_t         i_mtime,
  output logic                     o_msip_we,
  output logic                     o_mtimecmp_we,
  output logic                     o_mtime_we,
  output clint_pkg::xlen_t         o_wr_data,
  output clint_pkg::be_t           o_wr_byte_en
);

  import clint_pkg::*;

  localparam logic [`CLINT_ADDR_W-1:0] MSIP_ADDR     = `CLINT_BASE_ADDR + `CLINT_MSIP_OFS;
  localparam logic [`CLINT_ADDR_W-1:0] MTIMECMP_ADDR = `CLINT_BASE_ADDR + `CLINT_MTIMECMP_OFS;
  localparam logic [`CLINT_ADDR_W-1:0] MTIME_ADDR    = `CLINT_BASE_ADDR + `CLINT_MTIME_OFS;

  logic  w_req_fire;
  logic  w_wr_fire;
  logic  w_rd_fire;
  logic  w_hit_msip;
  logic  w_hit_mtimecmp;
  logic  w_hit_mtime;
  xlen_t w_rd_data;

  logic  r_resp_valid;
  tag_t  r_resp_tag;
  xlen_t r_resp_data;

  // --------------------------------------------------------------------------
  // accept and decode
  // --------------------------------------------------------------------------

  assign o_req_ready = !(r_resp_valid && !i_resp_ready);  // stall only on a held response
  assign w_req_fire  = i_req_valid && o_req_ready;
  assign w_wr_fire   = w_req_fire && (i_req_cmd == M_XWR);
  assign w_rd_fire   = w_req_fire && (i_req_cmd == M_XRD);

  assign w_hit_msip     = (i_req_addr == MSIP_ADDR);
  assign w_hit_mtimecmp = (i_req_addr == MTIMECMP_ADDR);
  assign w_hit_mtime    = (i_req_addr == MTIME_ADDR);

  assign o_msip_we     = w_wr_fire && w_hit_msip;
  assign o_mtimecmp_we = w_wr_fire && w_hit_mtimecmp;
  assign o_mtime_we    = w_wr_fire && w_hit_mtime;
  assign o_wr_data     = i_req_data;
  assign o_wr_byte_en  = i_req_byte_en;

  always_comb begin
    w_rd_data = '0;  // unmapped reads still answer, with zero
    if (w_hit_msip) begin
      w_rd_data = xlen_t'(i_msip);
    end else if (w_hit_mtimecmp) begin
      w_rd_data = i_mtimecmp;
    end else if (w_hit_mtime) begin
      w_rd_data = i_mtime;
    end
  end

  // --------------------------------------------------------------------------
  // response register
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else if (w_req_fire) begin
      r_resp_valid <= w_rd_fire;  // old response, if any, drains this cycle
    end else if (i_resp_ready) begin
      r_resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_rd_fire) begin
      r_resp_tag  <= i_req_tag;
      r_resp_data <= w_rd_data;  // value before this edge's update
    end
  end

  assign o_resp_valid = r_resp_valid;
  assign o_resp_tag   = r_resp_tag;
  assign o_resp_data  = r_resp_data;

  a_resp_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_resp_valid && !i_resp_ready)
      |=> o_resp_valid && $stable(o_resp_tag) && $stable(o_resp_data))
    else $error("response changed while stalled");

  a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0({o_msip_we, o_mtimecmp_we, o_mtime_we}))
    else $error("more than one write strobe");

endmodule

// File: clint_top.sv
/* CLINT for one hart on the load/store mmio port. Connects the bus slave,
   the msip/mtimecmp registers and the mtime timebase. */

`include "clint_settings.svh"

module clint_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_req_valid,
  input  clint_pkg::mem_cmd_t      i_req_cmd,
  input  logic [`CLINT_ADDR_W-1:0] i_req_addr,
  input  clint_pkg::tag_t          i_req_tag,
  input  clint_pkg::xlen_t         i_req_data,
  input  clint_pkg::be_t           i_req_byte_en,
  output logic                     o_req_ready,

  output logic                     o_resp_valid,
  output clint_pkg::tag_t          o_resp_tag,
  output clint_pkg::xlen_t         o_resp_data,
  input  logic                     i_resp_ready,

  output logic                     o_ipi,
  output logic                     o_timer_irq,
  output logic                     o_timer_irq_clear
);

  import clint_pkg::*;

  logic  w_msip_we;
  logic  w_mtimecmp_we;
  logic  w_mtime_we;
  xlen_t w_wr_data;
  be_t   w_wr_byte_en;
  logic  w_msip;
  xlen_t w_mtimecmp;
  xlen_t w_mtime;

  clint_bus_slave u_bus_slave (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req_valid   (i_req_valid),
    .i_req_cmd     (i_req_cmd),
    .i_req_addr    (i_req_addr),
    .i_req_tag     (i_req_tag),
    .i_req_data    (i_req_data),
    .i_req_byte_en (i_req_byte_en),
    .o_req_ready   (o_req_ready),
    .o_resp_valid  (o_resp_valid),
    .o_resp_tag    (o_resp_tag),
    .o_resp_data   (o_resp_data),
    .i_resp_ready  (i_resp_ready),
    .i_msip        (w_msip),
    .i_mtimecmp    (w_mtimecmp),
    .i_mtime       (w_mtime),
    .o_msip_we     (w_msip_we),
    .o_mtimecmp_we (w_mtimecmp_we),
    .o_mtime_we    (w_mtime_we),
    .o_wr_data     (w_wr_data),
    .o_wr_byte_en  (w_wr_byte_en)
  );

  clint_regs u_regs (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_msip_we         (w_msip_we),
    .i_mtimecmp_we     (w_mtimecmp_we),
    .i_wr_data         (w_wr_data),
    .i_wr_byte_en      (w_wr_byte_en),
    .i_mtime           (w_mtime),
    .o_msip            (w_msip),
    .o_mtimecmp        (w_mtimecmp),
    .o_ipi             (o_ipi),
    .o_timer_irq       (o_timer_irq),
    .o_timer_irq_clear (o_timer_irq_clear)
  );

  clint_timebase u_timebase (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_mtime_we   (w_mtime_we),
    .i_wr_data    (w_wr_data),
    .i_wr_byte_en (w_wr_byte_en),
    .o_mtime      (w_mtime)
  );

endmodule

// File: clint_tb.sv
/* Self-checking testbench for the CLINT. Random requests run against a reference
   model of the registers, prescaler, mtime and interrupt lines. */

`include "clint_settings.svh"

module clint_tb;

  import clint_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_TXN    = 3000;
  localparam int MARGIN     = 2000;  // reset, drain and the quiet mtime phase
  localparam int TICK_LEN   = 1 << `CLINT_TICK_DIV_W;

  localparam logic [`CLINT_ADDR_W-1:0] MSIP_ADDR     = `CLINT_BASE_ADDR + `CLINT_MSIP_OFS;
  localparam logic [`CLINT_ADDR_W-1:0] MTIMECMP_ADDR = `CLINT_BASE_ADDR + `CLINT_MTIMECMP_OFS;
  localparam logic [`CLINT_ADDR_W-1:0] MTIME_ADDR    = `CLINT_BASE_ADDR + `CLINT_MTIME_OFS;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_req_valid;
  mem_cmd_t                 i_req_cmd;
  logic [`CLINT_ADDR_W-1:0] i_req_addr;
  tag_t                     i_req_tag;
  xlen_t                    i_req_data;
  be_t                      i_req_byte_en;
  logic                     o_req_ready;
  logic                     o_resp_valid;
  tag_t                     o_resp_tag;
  xlen_t                    o_resp_data;
  logic                     i_resp_ready;
  logic                     o_ipi;
  logic                     o_timer_irq;
  logic                     o_timer_irq_clear;

  // reference model
  logic  m_msip;
  xlen_t m_mtimecmp;
  xlen_t m_mtime;
  int    m_cycles;          // cycles since reset, mirrors the prescaler
  tag_t  exp_tag_q[$];
  xlen_t exp_data_q[$];

  logic  last_accept;       // request on the bus was taken at the coming edge
  logic  prev_held;
  tag_t  prev_tag;
  xlen_t prev_data;
  logic  traffic_done;
  int    n_issued;
  int    n_reads;
  int    n_resp;
  int    err_value;
  int    err_other;

  clint_top uut (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_req_valid       (i_req_valid),
    .i_req_cmd         (i_req_cmd),
    .i_req_addr        (i_req_addr),
    .i_req_tag         (i_req_tag),
    .i_req_data        (i_req_data),
    .i_req_byte_en     (i_req_byte_en),
    .o_req_ready       (o_req_ready),
    .o_resp_valid      (o_resp_valid),
    .o_resp_tag        (o_resp_tag),
    .o_resp_data       (o_resp_data),
    .i_resp_ready      (i_resp_ready),
    .o_ipi             (o_ipi),
    .o_timer_irq       (o_timer_irq),
    .o_timer_irq_clear (o_timer_irq_clear)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD/2) i_clk = ~i_clk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  function automatic xlen_t lane_update(input xlen_t old_val, input xlen_t new_val,
                                        input be_t lanes);
    xlen_t mask;
    for (int b = 0; b < `CLINT_XLEN/8; b++) begin
      mask[8*b +: 8] = {8{lanes[b]}};
    end
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic xlen_t expected_read(input logic [`CLINT_ADDR_W-1:0] addr);
    xlen_t val;
    val = '0;  // unmapped
    if (addr == MSIP_ADDR) begin
      val[0] = m_msip;
    end else if (addr == MTIMECMP_ADDR) begin
      val = m_mtimecmp;
    end else if (addr == MTIME_ADDR) begin
      val = m_mtime;
    end
    return val;
  endfunction

  function automatic logic [`CLINT_ADDR_W-1:0] random_addr();
    logic [`CLINT_ADDR_W-1:0] addr;
    case ($urandom % 8)
      0, 1:    addr = MSIP_ADDR;
      2, 3:    addr = MTIMECMP_ADDR;
      4, 5:    addr = MTIME_ADDR;
      6:       addr = MTIME_ADDR + 32'h8;  // just past the map
      default: addr = `CLINT_BASE_ADDR + ($urandom & 32'hfff8);
    endcase
    return addr;
  endfunction

  task automatic report_mismatch(input string what, input xlen_t got, input xlen_t exp);
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    err_value++;
  endtask

  task automatic start_request();
    i_req_valid   <= 1'b1;
    i_req_cmd     <= ($urandom % 2 == 0) ? M_XRD : M_XWR;
    i_req_addr    <= random_addr();
    i_req_tag     <= tag_t'($urandom);
    i_req_data    <= ($urandom % 2 == 0) ? xlen_t'($urandom % 300) : {$urandom, $urandom};
    i_req_byte_en <= ($urandom % 3 == 0) ? be_t'($urandom) : 8'hff;
    n_issued++;
  endtask

  task automatic send_read(input logic [`CLINT_ADDR_W-1:0] addr);
    @(posedge i_clk);
    i_req_valid   <= 1'b1;
    i_req_cmd     <= M_XRD;
    i_req_addr    <= addr;
    i_req_tag     <= tag_t'(n_issued);
    i_req_byte_en <= '0;
    n_issued++;
    @(posedge i_clk);
    while (!last_accept) @(posedge i_clk);
    i_req_valid <= 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // model and checks, sampled mid-cycle where everything is settled
  // --------------------------------------------------------------------------

  always @(negedge i_clk) begin : model_step
    logic accept;
    logic is_wr;
    logic exp_valid;
    logic exp_ready;
    logic exp_clear;
    if (i_reset_n !== 1'b1) begin
      m_msip      = 1'b0;
      m_mtimecmp  = '0;
      m_mtime     = '0;
      m_cycles    = 0;
      last_accept = 1'b0;
      prev_held   = 1'b0;
    end else begin
      exp_valid = (exp_tag_q.size() != 0);
      exp_ready = !(exp_valid && !i_resp_ready);
      accept    = i_req_valid && o_req_ready;
      is_wr     = accept && (i_req_cmd == M_XWR);
      exp_clear = is_wr && (i_req_addr == MTIMECMP_ADDR);

      if (o_resp_valid !== exp_valid)
        report_mismatch("response valid", xlen_t'(o_resp_valid), xlen_t'(exp_valid));
      if (exp_valid && o_resp_valid) begin
        if (o_resp_tag !== exp_tag_q[0])
          report_mismatch("response tag", xlen_t'(o_resp_tag), xlen_t'(exp_tag_q[0]));
        if (o_resp_data !== exp_data_q[0])
          report_mismatch("response data", o_resp_data, exp_data_q[0]);
      end
      if (prev_held && (o_resp_tag !== prev_tag || o_resp_data !== prev_data))
        report_mismatch("stalled response moved", o_resp_data, prev_data);
      if (o_req_ready !== exp_ready)
        report_mismatch("request ready", xlen_t'(o_req_ready), xlen_t'(exp_ready));
      if (o_ipi !== m_msip)
        report_mismatch("ipi", xlen_t'(o_ipi), xlen_t'(m_msip));
      if (o_timer_irq !== (m_mtime >= m_mtimecmp))
        report_mismatch("timer irq", xlen_t'(o_timer_irq), xlen_t'(m_mtime >= m_mtimecmp));
      if (o_timer_irq_clear !== exp_clear)
        report_mismatch("timer irq clear", xlen_t'(o_timer_irq_clear), xlen_t'(exp_clear));

      prev_held = o_resp_valid && !i_resp_ready;
      prev_tag  = o_resp_tag;
      prev_data = o_resp_data;

      if (exp_valid && i_resp_ready) begin  // response completes at the edge
        void'(exp_tag_q.pop_front());
        void'(exp_data_q.pop_front());
        n_resp++;
      end
      if (accept && i_req_cmd == M_XRD) begin
        exp_tag_q.push_back(i_req_tag);
        exp_data_q.push_back(expected_read(i_req_addr));  // value before the edge
        n_reads++;
      end

      // state after the coming edge
      if (is_wr && i_req_addr == MSIP_ADDR && i_req_byte_en[0])
        m_msip = i_req_data[0];
      if (is_wr && i_req_addr == MTIMECMP_ADDR)
        m_mtimecmp = lane_update(m_mtimecmp, i_req_data, i_req_byte_en);
      if (is_wr && i_req_addr == MTIME_ADDR) begin
        m_mtime = lane_update(m_mtime, i_req_data, i_req_byte_en);  // store beats tick
      end else if (m_cycles % TICK_LEN == TICK_LEN - 1) begin
        m_mtime = m_mtime + 64'd1;
      end
      m_cycles++;
      last_accept = accept;
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h647b));
    i_reset_n     = 1'b0;
    i_req_valid   = 1'b0;
    i_req_cmd     = M_XRD;
    i_req_addr    = '0;
    i_req_tag     = '0;
    i_req_data    = '0;
    i_req_byte_en = '0;
    i_resp_ready  = 1'b0;
    traffic_done  = 1'b0;
    n_issued      = 0;
    n_reads       = 0;
    n_resp        = 0;
    err_value     = 0;
    err_other     = 0;
    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;

    while (!traffic_done) begin
      @(posedge i_clk);
      i_resp_ready <= ($urandom % 4 != 0);
      if (!i_req_valid || last_accept) begin  // bus slot is free
        if (n_issued == NUM_TXN) begin
          i_req_valid  <= 1'b0;
          traffic_done = 1'b1;
        end else if ($urandom % 4 == 0) begin
          i_req_valid <= 1'b0;  // idle gap
        end else begin
          start_request();
        end
      end
    end

    @(posedge i_clk);
    i_resp_ready <= 1'b1;
    while (exp_tag_q.size() != 0) @(posedge i_clk);

    // quiet stretch, mtime only ticks
    for (int k = 0; k < 6; k++) begin
      repeat (50) @(posedge i_clk);
      send_read(MTIME_ADDR);
    end
    repeat (4) @(posedge i_clk);

    if (exp_tag_q.size() != 0) begin
      $display("read responses never arrived: %0d still pending", exp_tag_q.size());
      err_other++;
    end
    $display("errors: %0d value, %0d other (%0d requests, %0d reads, %0d responses)",
             err_value, err_other, n_issued, n_reads, n_resp);
    if (err_value + err_other == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (NUM_TXN * 20 + MARGIN) @(posedge i_clk);
    $display("run did not finish in time, the bus or the response path hung");
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: clint.f
+incdir+.
clint_pkg.sv
clint_timebase.sv
clint_regs.sv
clint_bus_slave.sv
clint_top.sv
clint_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the CLINT

TOP = clint_tb
LOG = sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

obj_dir/V$(TOP): clint.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -j 0 -f clint.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f clint.f --top-module $(TOP)
	verilator --lint-only --timing --assert -f clint.f --top-module clint_top

clean:
	rm -rf obj_dir $(LOG)
